// File: id_stage_pkg.sv
package id_stage_pkg;

    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;
    parameter int exccode_w  = 5;
    parameter int alu_op_w   = 12;

    // one-hot alu operation, bit positions
    parameter int alu_add  = 0;
    parameter int alu_sub  = 1;
    parameter int alu_slt  = 2;
    parameter int alu_sltu = 3;
    parameter int alu_and  = 4;
    parameter int alu_nor  = 5;
    parameter int alu_or   = 6;
    parameter int alu_xor  = 7;
    parameter int alu_sll  = 8;
    parameter int alu_srl  = 9;
    parameter int alu_sra  = 10;
    parameter int alu_lui  = 11; // imm into upper half

    parameter logic [exccode_w-1:0] exc_none = 5'd0;
    parameter logic [exccode_w-1:0] exc_sys  = 5'd8;
    parameter logic [exccode_w-1:0] exc_bp   = 5'd9;
    parameter logic [exccode_w-1:0] exc_ri   = 5'd10; // reserved instruction

    parameter logic [5:0] op_special = 6'h00;
    parameter logic [5:0] op_addiu   = 6'h09;
    parameter logic [5:0] op_andi    = 6'h0c;
    parameter logic [5:0] op_ori     = 6'h0d;
    parameter logic [5:0] op_xori    = 6'h0e;
    parameter logic [5:0] op_lui     = 6'h0f;
    parameter logic [5:0] op_lw      = 6'h23;
    parameter logic [5:0] op_sw      = 6'h2b;

    parameter logic [5:0] fn_sll     = 6'h00;
    parameter logic [5:0] fn_srl     = 6'h02;
    parameter logic [5:0] fn_sra     = 6'h03;
    parameter logic [5:0] fn_syscall = 6'h0c;
    parameter logic [5:0] fn_break   = 6'h0d;
    parameter logic [5:0] fn_addu    = 6'h21;
    parameter logic [5:0] fn_subu    = 6'h23;
    parameter logic [5:0] fn_and     = 6'h24;
    parameter logic [5:0] fn_or      = 6'h25;
    parameter logic [5:0] fn_xor     = 6'h26;
    parameter logic [5:0] fn_nor     = 6'h27;
    parameter logic [5:0] fn_slt     = 6'h2a;
    parameter logic [5:0] fn_sltu    = 6'h2b;

    typedef struct packed {
        logic [5:0]            op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    // same 32-bit word, read as R or I format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_u;

endpackage

// File: decode_if.sv
`timescale 1ns/1ps

interface decode_if;

    logic [id_stage_pkg::reg_addr_w-1:0] rs;
    logic [id_stage_pkg::reg_addr_w-1:0] rt;
    logic                                rs_used; // rs value is read
    logic                                rt_used;
    logic                                src1_is_sa;
    logic                                src2_is_imm;
    logic                                imm_zero_ext; // else sign extend
    logic [15:0]                         imm;
    logic [4:0]                          sa;

    modport decoder (
        output rs, rt, rs_used, rt_used, src1_is_sa, src2_is_imm,
               imm_zero_ext, imm, sa
    );

    modport operand (
        input rs, rt, rs_used, rt_used, src1_is_sa, src2_is_imm,
              imm_zero_ext, imm, sa
    );

endinterface

// File: id_pipe_reg.sv
`timescale 1ns/1ps

module id_pipe_reg (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               flush,
    input  logic                               fs_to_ds_valid,
    input  logic                               es_allowin,
    input  logic                               stall,
    input  logic [id_stage_pkg::xlen-1:0]      fs_pc,
    input  id_stage_pkg::inst_word_u           fs_inst,
    input  logic                               fs_ex,
    input  logic [id_stage_pkg::exccode_w-1:0] fs_exccode,
    output logic                               ds_valid,
    output logic                               ds_allowin,
    output logic                               ds_to_es_valid,
    output logic [id_stage_pkg::xlen-1:0]      ds_pc,
    output id_stage_pkg::inst_word_u           ds_inst,
    output logic                               ds_fs_ex,
    output logic [id_stage_pkg::exccode_w-1:0] ds_fs_exccode
);

    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0; // flush wins over accept
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_pc         <= '0;
            ds_inst       <= '0;
            ds_fs_ex      <= 1'b0;
            ds_fs_exccode <= '0;
        end else if (fs_to_ds_valid && ds_allowin) begin
            ds_pc         <= fs_pc;
            ds_inst       <= fs_inst;
            ds_fs_ex      <= fs_ex;
            ds_fs_exccode <= fs_exccode;
        end
    end

    // held instruction must not move while EXE or a hazard blocks it
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (ds_valid && !ds_allowin && !flush) |=> $stable(ds_inst) && $stable(ds_pc))
        else $error("held instruction changed under back-pressure");

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  id_stage_pkg::inst_word_u              ds_inst,
    input  logic                                  ds_fs_ex,
    input  logic [id_stage_pkg::exccode_w-1:0]    ds_fs_exccode,
    decode_if.decoder                             dec,
    output logic [id_stage_pkg::alu_op_w-1:0]     alu_op,
    output logic [id_stage_pkg::reg_addr_w-1:0]   dest,
    output logic                                  gr_we,
    output logic                                  mem_we,
    output logic                                  load_op,
    output logic                                  ds_ex,
    output logic [id_stage_pkg::exccode_w-1:0]    ds_exccode
);

    logic is_special, sa_zero, rs_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra;
    logic inst_addiu, inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic inst_syscall, inst_break;
    logic r_alu, shift, imm_alu, inst_defined, dst_is_rt;

    assign is_special = ds_inst.r.op == id_stage_pkg::op_special;
    assign sa_zero    = ds_inst.r.sa == 5'd0;
    assign rs_zero    = ds_inst.r.rs == 5'd0;

    assign inst_addu = is_special && ds_inst.r.funct == id_stage_pkg::fn_addu && sa_zero;
    assign inst_subu = is_special && ds_inst.r.funct == id_stage_pkg::fn_subu && sa_zero;
    assign inst_slt  = is_special && ds_inst.r.funct == id_stage_pkg::fn_slt  && sa_zero;
    assign inst_sltu = is_special && ds_inst.r.funct == id_stage_pkg::fn_sltu && sa_zero;
    assign inst_and  = is_special && ds_inst.r.funct == id_stage_pkg::fn_and  && sa_zero;
    assign inst_or   = is_special && ds_inst.r.funct == id_stage_pkg::fn_or   && sa_zero;
    assign inst_xor  = is_special && ds_inst.r.funct == id_stage_pkg::fn_xor  && sa_zero;
    assign inst_nor  = is_special && ds_inst.r.funct == id_stage_pkg::fn_nor  && sa_zero;
    assign inst_sll  = is_special && ds_inst.r.funct == id_stage_pkg::fn_sll  && rs_zero;
    assign inst_srl  = is_special && ds_inst.r.funct == id_stage_pkg::fn_srl  && rs_zero;
    assign inst_sra  = is_special && ds_inst.r.funct == id_stage_pkg::fn_sra  && rs_zero;
    assign inst_syscall = is_special && ds_inst.r.funct == id_stage_pkg::fn_syscall; // code ignored
    assign inst_break   = is_special && ds_inst.r.funct == id_stage_pkg::fn_break;

    assign inst_addiu = ds_inst.i.op == id_stage_pkg::op_addiu;
    assign inst_andi  = ds_inst.i.op == id_stage_pkg::op_andi;
    assign inst_ori   = ds_inst.i.op == id_stage_pkg::op_ori;
    assign inst_xori  = ds_inst.i.op == id_stage_pkg::op_xori;
    assign inst_lui   = ds_inst.i.op == id_stage_pkg::op_lui && rs_zero;
    assign inst_lw    = ds_inst.i.op == id_stage_pkg::op_lw;
    assign inst_sw    = ds_inst.i.op == id_stage_pkg::op_sw;

    assign shift   = inst_sll | inst_srl | inst_sra;
    assign r_alu   = inst_addu | inst_subu | inst_slt | inst_sltu |
                     inst_and | inst_or | inst_xor | inst_nor;
    assign imm_alu = inst_addiu | inst_andi | inst_ori | inst_xori | inst_lui;
    assign inst_defined = r_alu | shift | imm_alu | inst_lw | inst_sw |
                          inst_syscall | inst_break;

    assign alu_op[id_stage_pkg::alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw;
    assign alu_op[id_stage_pkg::alu_sub]  = inst_subu;
    assign alu_op[id_stage_pkg::alu_slt]  = inst_slt;
    assign alu_op[id_stage_pkg::alu_sltu] = inst_sltu;
    assign alu_op[id_stage_pkg::alu_and]  = inst_and | inst_andi;
    assign alu_op[id_stage_pkg::alu_nor]  = inst_nor;
    assign alu_op[id_stage_pkg::alu_or]   = inst_or | inst_ori;
    assign alu_op[id_stage_pkg::alu_xor]  = inst_xor | inst_xori;
    assign alu_op[id_stage_pkg::alu_sll]  = inst_sll;
    assign alu_op[id_stage_pkg::alu_srl]  = inst_srl;
    assign alu_op[id_stage_pkg::alu_sra]  = inst_sra;
    assign alu_op[id_stage_pkg::alu_lui]  = inst_lui;

    assign dst_is_rt = imm_alu | inst_lw;
    assign gr_we     = r_alu | shift | dst_is_rt;
    assign mem_we    = inst_sw;
    assign load_op   = inst_lw;
    assign dest      = !gr_we    ? 5'd0 :
                       dst_is_rt ? ds_inst.i.rt : ds_inst.r.rd;

    assign dec.rs           = ds_inst.r.rs;
    assign dec.rt           = ds_inst.r.rt;
    assign dec.rs_used      = r_alu | inst_addiu | inst_andi | inst_ori | inst_xori |
                              inst_lw | inst_sw; // lui and shifts skip rs
    assign dec.rt_used      = r_alu | shift | inst_sw;
    assign dec.src1_is_sa   = shift;
    assign dec.src2_is_imm  = imm_alu | inst_lw | inst_sw;
    assign dec.imm_zero_ext = inst_andi | inst_ori | inst_xori | inst_lui;
    assign dec.imm          = ds_inst.i.imm;
    assign dec.sa           = ds_inst.r.sa;

    assign ds_ex      = ds_fs_ex | !inst_defined | inst_syscall | inst_break;
    assign ds_exccode = ds_fs_ex      ? ds_fs_exccode          :
                        !inst_defined ? id_stage_pkg::exc_ri   :
                        inst_syscall  ? id_stage_pkg::exc_sys  :
                        inst_break    ? id_stage_pkg::exc_bp   : id_stage_pkg::exc_none;

    // overlapping opcode matches would show up here
    always_comb begin
        if (!$isunknown(ds_inst)) begin
            a_alu_onehot: assert ($onehot0(alu_op))
                else $error("alu_op not one-hot: %b", alu_op);
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [id_stage_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_stage_pkg::reg_addr_w-1:0] raddr2,
    input  logic                                we,
    input  logic [id_stage_pkg::reg_addr_w-1:0] waddr,
    input  logic [id_stage_pkg::xlen-1:0]       wdata,
    output logic [id_stage_pkg::xlen-1:0]       rdata1,
    output logic [id_stage_pkg::xlen-1:0]       rdata2
);

    logic [id_stage_pkg::xlen-1:0] rf [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

// File: operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    decode_if.operand                           dec,
    input  logic                                ds_valid,
    input  logic [id_stage_pkg::xlen-1:0]       ds_pc,
    input  logic [id_stage_pkg::xlen-1:0]       rf_rdata1,
    input  logic [id_stage_pkg::xlen-1:0]       rf_rdata2,
    input  logic [id_stage_pkg::reg_addr_w-1:0] exe_dest,
    input  logic [id_stage_pkg::reg_addr_w-1:0] mem_dest,
    input  logic [id_stage_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [id_stage_pkg::xlen-1:0]       exe_result,
    input  logic [id_stage_pkg::xlen-1:0]       mem_result,
    input  logic [id_stage_pkg::xlen-1:0]       wb_result,
    input  logic                                exe_load_op,
    input  logic                                mem_load_op,
    output logic [id_stage_pkg::xlen-1:0]       src1,
    output logic [id_stage_pkg::xlen-1:0]       src2,
    output logic [id_stage_pkg::xlen-1:0]       store_data,
    output logic                                stall
);

    logic rs_exe, rs_mem, rs_wb, rt_exe, rt_mem, rt_wb;
    logic rs_load_hit, rt_load_hit;
    logic [id_stage_pkg::xlen-1:0] rs_value, rt_value, imm_ext;

    function automatic logic src_match(
        input logic [id_stage_pkg::reg_addr_w-1:0] src,
        input logic                                used,
        input logic [id_stage_pkg::reg_addr_w-1:0] dst
    );
        return used && (src != 5'd0) && (src == dst); // r0 never forwards
    endfunction

    assign rs_exe = src_match(dec.rs, dec.rs_used, exe_dest);
    assign rs_mem = src_match(dec.rs, dec.rs_used, mem_dest);
    assign rs_wb  = src_match(dec.rs, dec.rs_used, wb_dest);
    assign rt_exe = src_match(dec.rt, dec.rt_used, exe_dest);
    assign rt_mem = src_match(dec.rt, dec.rt_used, mem_dest);
    assign rt_wb  = src_match(dec.rt, dec.rt_used, wb_dest);

    // youngest producer wins
    assign rs_value = rs_exe ? exe_result :
                      rs_mem ? mem_result :
                      rs_wb  ? wb_result  : rf_rdata1;
    assign rt_value = rt_exe ? exe_result :
                      rt_mem ? mem_result :
                      rt_wb  ? wb_result  : rf_rdata2;

    // load data not ready yet in exe or mem
    assign rs_load_hit = (rs_exe && exe_load_op) || (!rs_exe && rs_mem && mem_load_op);
    assign rt_load_hit = (rt_exe && exe_load_op) || (!rt_exe && rt_mem && mem_load_op);
    assign stall       = ds_valid && (rs_load_hit || rt_load_hit);

    assign imm_ext = dec.imm_zero_ext ? {16'd0, dec.imm} : {{16{dec.imm[15]}}, dec.imm};

    assign src1       = dec.src1_is_sa ? {27'd0, dec.sa} : rs_value;
    assign src2       = dec.src2_is_imm ? imm_ext : rt_value;
    assign store_data = rt_value; // sw data, always rt

    // rs not marked as read when sa feeds src1
    always_comb begin
        if (!$isunknown({dec.src1_is_sa, dec.rs_used})) begin
            a_sa_rs: assert (!(dec.src1_is_sa && dec.rs_used))
                else $error("shift marks rs as read, pc %h", ds_pc);
        end
    end

endmodule

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                fs_to_ds_valid,
    input  logic [id_stage_pkg::xlen-1:0]       fs_pc,
    input  logic [31:0]                         fs_inst,
    input  logic                                fs_ex,
    input  logic [id_stage_pkg::exccode_w-1:0]  fs_exccode,
    input  logic                                es_allowin,
    input  logic                                rf_we,
    input  logic [id_stage_pkg::reg_addr_w-1:0] rf_waddr,
    input  logic [id_stage_pkg::xlen-1:0]       rf_wdata,
    input  logic [id_stage_pkg::reg_addr_w-1:0] exe_dest,
    input  logic [id_stage_pkg::xlen-1:0]       exe_result,
    input  logic                                exe_load_op,
    input  logic [id_stage_pkg::reg_addr_w-1:0] mem_dest,
    input  logic [id_stage_pkg::xlen-1:0]       mem_result,
    input  logic                                mem_load_op,
    input  logic [id_stage_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [id_stage_pkg::xlen-1:0]       wb_result,
    output logic                                ds_allowin,
    output logic                                ds_to_es_valid,
    output logic [id_stage_pkg::xlen-1:0]       es_pc,
    output logic [id_stage_pkg::alu_op_w-1:0]   es_alu_op,
    output logic [id_stage_pkg::xlen-1:0]       es_src1,
    output logic [id_stage_pkg::xlen-1:0]       es_src2,
    output logic [id_stage_pkg::xlen-1:0]       es_store_data,
    output logic [id_stage_pkg::reg_addr_w-1:0] es_dest,
    output logic                                es_gr_we,
    output logic                                es_mem_we,
    output logic                                es_load_op,
    output logic                                es_ex,
    output logic [id_stage_pkg::exccode_w-1:0]  es_exccode
);

    logic                               ds_valid, stall, ds_fs_ex;
    logic [id_stage_pkg::exccode_w-1:0] ds_fs_exccode;
    logic [id_stage_pkg::xlen-1:0]      rf_rdata1, rf_rdata2;
    id_stage_pkg::inst_word_u           ds_inst;

    decode_if dec_bus ();

    id_pipe_reg i_pipe_reg (
        .clk, .reset, .flush, .fs_to_ds_valid, .es_allowin, .stall,
        .fs_pc, .fs_inst, .fs_ex, .fs_exccode,
        .ds_valid, .ds_allowin, .ds_to_es_valid,
        .ds_pc (es_pc), .ds_inst, .ds_fs_ex, .ds_fs_exccode
    );

    inst_decoder i_decoder (
        .ds_inst, .ds_fs_ex, .ds_fs_exccode, .dec (dec_bus.decoder),
        .alu_op (es_alu_op), .dest (es_dest), .gr_we (es_gr_we), .mem_we (es_mem_we),
        .load_op (es_load_op), .ds_ex (es_ex), .ds_exccode (es_exccode)
    );

    regfile i_regfile (
        .clk, .reset,
        .raddr1 (dec_bus.rs), .raddr2 (dec_bus.rt),
        .we (rf_we), .waddr (rf_waddr), .wdata (rf_wdata),
        .rdata1 (rf_rdata1), .rdata2 (rf_rdata2)
    );

    operand_bypass i_bypass (
        .dec (dec_bus.operand), .ds_valid, .ds_pc (es_pc), .rf_rdata1, .rf_rdata2,
        .exe_dest, .mem_dest, .wb_dest, .exe_result, .mem_result, .wb_result,
        .exe_load_op, .mem_load_op,
        .src1 (es_src1), .src2 (es_src2), .store_data (es_store_data), .stall
    );

endmodule

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;

    logic        clk, reset, flush, fs_to_ds_valid, fs_ex, es_allowin, rf_we;
    logic        exe_load_op, mem_load_op;
    logic [31:0] fs_pc, fs_inst, rf_wdata, exe_result, mem_result, wb_result;
    logic [4:0]  fs_exccode, rf_waddr, exe_dest, mem_dest, wb_dest;
    logic        ds_allowin, ds_to_es_valid, es_gr_we, es_mem_we, es_load_op, es_ex;
    logic [31:0] es_pc, es_src1, es_src2, es_store_data;
    logic [11:0] es_alu_op;
    logic [4:0]  es_dest, es_exccode;

    logic [31:0] shadow [32];
    logic [31:0] lfsr, m_inst, m_pc, e_rs, e_rt, e_src1, e_src2;
    logic        m_valid, m_fs_ex, m_allowin, e_stall, e_gr_we, e_ex, shift, sys, bp;
    logic        rs_used, rt_used, zero_ext;
    logic [4:0]  m_fs_code, e_dest, e_code, rs, rt;
    logic [5:0]  op, fn;
    logic [11:0] e_alu;
    int          value_errors, timeouts;

    localparam logic [5:0] fn_tab [11] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25,
                                           6'h26, 6'h27, 6'h00, 6'h02, 6'h03};
    localparam logic [5:0] op_tab [7]  = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f, 6'h23, 6'h2b};

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // youngest stage wins, then the shadow copy
    function automatic logic [31:0] fwd_value(input logic [4:0] r, input logic used);
        if (used && r != 5'd0 && r == exe_dest) return exe_result;
        if (used && r != 5'd0 && r == mem_dest) return mem_result;
        if (used && r != 5'd0 && r == wb_dest)  return wb_result;
        return shadow[r];
    endfunction

    function automatic logic load_hit(input logic [4:0] r, input logic used);
        if (!used || r == 5'd0) return 1'b0;
        return (r == exe_dest) ? exe_load_op : (r == mem_dest && mem_load_op);
    endfunction

    always_comb begin
        op = m_inst[31:26];
        fn = m_inst[5:0];
        rs = m_inst[25:21];
        rt = m_inst[20:16];
        e_alu = '0;
        if (op == 6'h00 && m_inst[10:6] == 5'd0) begin
            case (fn)
                6'h21: e_alu[0] = 1'b1;
                6'h23: e_alu[1] = 1'b1;
                6'h2a: e_alu[2] = 1'b1;
                6'h2b: e_alu[3] = 1'b1;
                6'h24: e_alu[4] = 1'b1;
                6'h27: e_alu[5] = 1'b1;
                6'h25: e_alu[6] = 1'b1;
                6'h26: e_alu[7] = 1'b1;
                default: ;
            endcase
        end
        if (op == 6'h00 && rs == 5'd0) begin
            case (fn)
                6'h00: e_alu[8] = 1'b1;
                6'h02: e_alu[9] = 1'b1;
                6'h03: e_alu[10] = 1'b1;
                default: ;
            endcase
        end
        case (op)
            6'h09, 6'h23, 6'h2b: e_alu[0] = 1'b1;
            6'h0c: e_alu[4] = 1'b1;
            6'h0d: e_alu[6] = 1'b1;
            6'h0e: e_alu[7] = 1'b1;
            6'h0f: e_alu[11] = (rs == 5'd0);
            default: ;
        endcase
        shift    = |e_alu[10:8];
        sys      = op == 6'h00 && fn == 6'h0c;
        bp       = op == 6'h00 && fn == 6'h0d;
        e_gr_we  = |e_alu && op != 6'h2b;
        e_dest   = !e_gr_we ? 5'd0 : (op != 6'h00 ? rt : m_inst[15:11]);
        e_ex     = m_fs_ex || !(|e_alu || sys || bp) || sys || bp;
        e_code   = m_fs_ex ? m_fs_code : !(|e_alu || sys || bp) ? 5'd10 :
                   sys ? 5'd8 : bp ? 5'd9 : 5'd0;
        rs_used  = |e_alu && !shift && !e_alu[11];
        rt_used  = (op == 6'h00 && |e_alu) || op == 6'h2b;
        zero_ext = op[5:2] == 4'b0011;
        e_rs     = fwd_value(rs, rs_used);
        e_rt     = fwd_value(rt, rt_used);
        e_src1   = shift ? {27'd0, m_inst[10:6]} : e_rs;
        e_src2   = (op != 6'h00 && |e_alu) ? (zero_ext ? {16'd0, m_inst[15:0]} :
                   {{16{m_inst[15]}}, m_inst[15:0]}) : e_rt;
        e_stall  = m_valid && (load_hit(rs, rs_used) || load_hit(rt, rt_used));
        m_allowin = !m_valid || (!e_stall && es_allowin);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            m_valid <= 1'b0;
            m_inst <= '0;
            m_pc <= '0;
            m_fs_ex <= 1'b0;
            m_fs_code <= '0;
        end else if (m_allowin) begin
            m_valid <= fs_to_ds_valid;
            if (fs_to_ds_valid) begin
                m_inst <= fs_inst;
                m_pc <= fs_pc;
                m_fs_ex <= fs_ex;
                m_fs_code <= fs_exccode;
            end
        end
        if (reset) begin
            for (int i = 0; i < 32; i++) shadow[i] <= '0;
        end else if (rf_we && rf_waddr != 5'd0) begin
            shadow[rf_waddr] <= rf_wdata;
        end
    end

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        value_errors++;
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    endtask

    a_valid: assert property (@(negedge clk) disable iff (reset)
        ds_to_es_valid == (m_valid && !e_stall))
        else fail_value("valid_out", 32'(m_valid && !e_stall), 32'(ds_to_es_valid));
    a_allowin: assert property (@(negedge clk) disable iff (reset) ds_allowin == m_allowin)
        else fail_value("allowin", 32'(m_allowin), 32'(ds_allowin));
    a_decode: assert property (@(negedge clk) disable iff (reset) !m_valid ||
        {es_alu_op, es_dest, es_gr_we, es_mem_we, es_load_op} ==
        {e_alu, e_dest, e_gr_we, op == 6'h2b, op == 6'h23})
        else fail_value("decode", 32'({e_alu, e_dest, e_gr_we, op == 6'h2b, op == 6'h23}),
                        32'({es_alu_op, es_dest, es_gr_we, es_mem_we, es_load_op}));
    a_exc: assert property (@(negedge clk) disable iff (reset) !m_valid ||
        {es_ex, es_exccode} == {e_ex, e_code})
        else fail_value("exception", 32'({e_ex, e_code}), 32'({es_ex, es_exccode}));
    a_pc: assert property (@(negedge clk) disable iff (reset) !m_valid || es_pc == m_pc)
        else fail_value("pc", m_pc, es_pc);
    a_src1: assert property (@(negedge clk) disable iff (reset) !m_valid || es_src1 == e_src1)
        else fail_value("src1", e_src1, es_src1);
    a_src2: assert property (@(negedge clk) disable iff (reset) !m_valid || es_src2 == e_src2)
        else fail_value("src2", e_src2, es_src2);
    a_store: assert property (@(negedge clk) disable iff (reset) !m_valid || es_store_data == e_rt)
        else fail_value("store_data", e_rt, es_store_data);

    task automatic drive_random();
        logic [31:0] w, r;
        logic [4:0]  sel;
        sel = 5'(lfsr_bits(5));
        w = lfsr_bits(32);
        r = lfsr_bits(9);
        w[25:21] = {2'b00, r[2:0]}; // few registers, many hazards
        w[20:16] = {2'b00, r[5:3]};
        w[15:11] = {2'b00, r[8:6]};
        if (sel < 5'd11) begin
            w[31:26] = 6'h00;
            w[5:0] = fn_tab[4'(sel)];
            if (sel < 5'd8) w[10:6] = 5'd0;
            else w[25:21] = 5'd0;
        end else if (sel < 5'd18) begin
            w[31:26] = op_tab[3'(sel - 5'd11)];
            if (w[31:26] == 6'h0f) w[25:21] = 5'd0;
        end else if (sel < 5'd20) begin
            w[31:26] = 6'h00;
            w[5:0] = (sel == 5'd18) ? 6'h0c : 6'h0d;
        end
        fs_inst <= w;
        fs_pc <= lfsr_bits(30) << 2;
        fs_to_ds_valid <= 2'(lfsr_bits(2)) != 2'd0;
        fs_ex <= 4'(lfsr_bits(4)) == 4'd0;
        fs_exccode <= 5'(lfsr_bits(5));
        es_allowin <= 2'(lfsr_bits(2)) != 2'd0;
        flush <= 5'(lfsr_bits(5)) == 5'd0;
        rf_we <= 1'(lfsr_bits(1));
        rf_waddr <= 5'(lfsr_bits(3));
        rf_wdata <= lfsr_bits(32);
        exe_dest <= 5'(lfsr_bits(3));
        mem_dest <= 5'(lfsr_bits(3));
        wb_dest <= 5'(lfsr_bits(3));
        exe_result <= lfsr_bits(32);
        mem_result <= lfsr_bits(32);
        wb_result <= lfsr_bits(32);
        exe_load_op <= 2'(lfsr_bits(2)) == 2'd0;
        mem_load_op <= 2'(lfsr_bits(2)) == 2'd0;
    endtask

    initial begin
        int waited;
        lfsr = 32'hade8_f6ac;
        value_errors = 0;
        timeouts = 0;
        reset = 1'b1;
        {flush, fs_to_ds_valid, fs_ex, es_allowin, rf_we, exe_load_op, mem_load_op} = '0;
        {fs_pc, fs_inst, rf_wdata, exe_result, mem_result, wb_result} = '0;
        {fs_exccode, rf_waddr, exe_dest, mem_dest, wb_dest} = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < 3000; n++) begin
            @(posedge clk);
            drive_random();
        end
        @(posedge clk);
        {fs_to_ds_valid, flush, exe_load_op, mem_load_op} <= '0;
        es_allowin <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while ((ds_to_es_valid || !ds_allowin) && waited < 20);
        if (waited >= 20) begin
            timeouts++;
            $display("stage did not drain within 20 cycles");
        end
        $display("errors: %0d value, %0d timeout", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: id_stage.f
id_stage_pkg.sv
decode_if.sv
id_pipe_reg.sv
inst_decoder.sv
regfile.sv
operand_bypass.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f id_stage.f --top-module tb_id_stage -o sim_id_stage &&
./obj_dir/sim_id_stage | tee /dev/stderr | grep -q "Regression passed" &&
echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
